// File: filelist.f
common/cpu_pkg.sv
design/cpu_alu.sv
cpu/cpu_regfile.sv
cpu/cpu_decoder.sv
cpu/cpu_sequencer.sv
cpu/cpu_top.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_cpu -f filelist.f -o sim_cpu
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log
if grep -q "^test passed$" sim.log; then
    exit 0
fi
exit 1

// File: sim/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam logic [31:0] SEED    = 32'hdf12_047d;
    localparam addr_t       PROG    = 16'h0200;          // Program area
    localparam addr_t       DATA    = 16'h0800;          // Result slots
    localparam int          MAX_INS = 4096;              // Reference runaway guard

    logic  CLK;
    logic  RESET;
    addr_t addr;
    byte_t din;
    byte_t dout;
    logic  wreq;

    byte_t       mem [0:65535];                          // DUT memory
    byte_t       rmem [0:65535];                         // Reference copy
    logic [31:0] lfsr;
    addr_t       gp;                                     // Program write pointer
    addr_t       slot;                                   // Next result address
    addr_t       exp_addr [$];
    byte_t       exp_data [$];
    int          limit;
    int          cycles;
    int          wr_idx;

    cpu_top u_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .addr  (addr),
        .din   (din),
        .dout  (dout),
        .wreq  (wreq)
    );

    assign din = mem[addr];                              // Asynchronous read

    always @(posedge CLK) begin
        if (wreq === 1'b1)
            mem[addr] <= dout;
    end

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // ------------------------------------------------------------------
    // Checking and random numbers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 32'h8020_0003;                 // x^32+x^22+x^2+x+1
        return out;
    endfunction

    function automatic byte_t rand_byte();
        byte_t r;
        r = '0;
        for (int i = 0; i < 8; i++)
            r = {r[6:0], rand_bit()};
        return r;
    endfunction

    task automatic put(input byte_t b);
        mem[gp] = b;
        gp      = gp + 1'b1;
    endtask

    task automatic ins2(input byte_t op, input byte_t b);
        put(op);
        put(b);
    endtask

    task automatic ins3(input byte_t op, input addr_t a);
        put(op);
        put(a[7:0]);
        put(a[15:8]);
    endtask

    task automatic store_slot(input byte_t op);          // STA, STX or STY absolute
        ins3(op, slot);
        slot = slot + 1'b1;
    endtask

    // ------------------------------------------------------------------
    // Program generator
    // ------------------------------------------------------------------
    task automatic build_program();
        logic [2:0] modes [5];
        byte_t      opc;
        addr_t      loc;
        byte_t      setters [5];
        byte_t      brs [8];
        modes   = '{3'b010, 3'b001, 3'b011, 3'b111, 3'b110};
        setters = '{8'hC9, 8'h69, 8'hE9, 8'hE0, 8'hC0}; // CMP ADC SBC CPX CPY
        brs     = '{8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0};
        for (int i = 0; i < 65536; i++)
            mem[i] = byte_t'(i[15:8] ^ {i[6:0], i[7]} ^ 8'h5a);  // Whole-address fill
        mem[RESET_VECTOR]      = PROG[7:0];
        mem[RESET_VECTOR + 1]  = PROG[15:8];
        gp   = PROG;
        slot = DATA;
        for (int op = 0; op < 8; op++) begin             // Group one with X and Y still zero
            if (op == 4)
                continue;
            if (op == 3 || op == 7)
                put(rand_bit() ? 8'h38 : 8'h18);         // Random carry in
            ins2(8'hA9, rand_byte());
            opc = {op[2:0], modes[op % 5], 2'b01};
            loc = (modes[op % 5] == 3'b001) ? addr_t'(16'h0010 + op) : addr_t'(16'h0880 + op);
            if (modes[op % 5] == 3'b010) begin
                ins2(opc, rand_byte());
            end else begin
                mem[loc] = rand_byte();
                if (modes[op % 5] == 3'b001)
                    ins2(opc, loc[7:0]);
                else
                    ins3(opc, loc);
            end
            store_slot(8'h8D);
        end
        ins2(8'hA2, rand_byte() | 8'h10);                // Addressing modes
        ins2(8'hA0, rand_byte() | 8'h10);
        ins3(8'hBD, 16'h09F8);                           // Always crosses a page
        store_slot(8'h8D);
        ins3(8'hB9, 16'h0AF0);
        ins3(8'h9D, 16'h0BF8);
        ins3(8'h99, 16'h0CF0);
        ins2(8'hA5, 8'h20);
        ins2(8'h85, 8'h21);
        ins3(8'hAD, 16'h0D00);
        ins3(8'h8D, 16'h0D01);
        ins2(8'hA5, 8'h21);
        store_slot(8'h8D);
        ins2(8'hA2, rand_byte());                        // Index registers
        ins2(8'hA0, rand_byte());
        put(8'hE8);
        put(8'hC8);
        put(8'hC8);
        put(8'hCA);
        put(8'h88);
        store_slot(8'h8E);
        store_slot(8'h8C);
        ins2(8'hA9, rand_byte());
        put(8'hAA);
        put(8'hA8);
        ins2(8'h86, 8'h22);
        put(8'hCA);
        ins2(8'h84, 8'h23);
        ins2(8'hA6, 8'h23);
        ins2(8'hA4, 8'h22);
        put(8'h8A);
        store_slot(8'h8D);
        put(8'h98);
        store_slot(8'h8D);
        ins3(8'hAE, slot - 1'b1);
        store_slot(8'h8E);
        for (int b = 0; b < 8; b++) begin                // Flags and branches
            ins2(8'hA9, rand_byte());
            ins2(8'hA2, rand_byte());
            ins2(8'hA0, rand_byte());
            if (b % 5 == 1 || b % 5 == 2)
                put(rand_bit() ? 8'h38 : 8'h18);
            ins2(setters[b % 5], rand_byte());
            ins2(brs[b], 8'h06);                         // Skip STA and JMP when taken
            store_slot(8'h8D);
            ins3(8'h4C, gp + 16'd6);
            store_slot(8'h8E);
        end
        ins3(8'h4C, 16'h06F0);                           // Taken branch across a page
        gp = 16'h06F0;
        put(8'h38);
        ins2(8'hB0, 8'h20);
        gp = 16'h0713;
        store_slot(8'h8C);
        ins2(8'hA9, 8'hA5);                              // JMP skips the marker write
        ins3(8'h4C, gp + 16'd6);
        ins3(8'h8D, 16'h08FF);
        store_slot(8'h8D);
        ins3(8'h4C, gp);                                 // Park
    endtask

    // ------------------------------------------------------------------
    // Reference 6502 model that returns the executed instruction count
    // ------------------------------------------------------------------
    function automatic int run_reference();
        addr_t      pc;
        addr_t      ea;
        addr_t      t;
        byte_t      a, x, y, op, m, r, sv;
        logic       n, v, z, c, upd, done, f;
        logic [8:0] s;
        int         count;
        pc = {rmem[RESET_VECTOR + 1], rmem[RESET_VECTOR]};
        {a, x, y} = '0;
        {n, v, z, c} = '0;
        count = 0;
        done  = 1'b0;
        while (!done && count < MAX_INS) begin
            op = rmem[pc];
            pc = pc + 1'b1;
            count++;
            ea = pc;
            if (op[1:0] == 2'b01 || op inside {8'hA0, 8'hA2, 8'hC0, 8'hE0} ||
                op inside {8'hA4, 8'hA6, 8'hC4, 8'hE4, 8'h84, 8'h86} ||
                op inside {8'hAC, 8'hAE, 8'hCC, 8'hEC, 8'h8C, 8'h8E}) begin
                case (op[4:2])
                    3'b001:  ea = {8'h00, rmem[pc]};
                    3'b011:  ea = {rmem[pc + 1], rmem[pc]};
                    3'b111:  ea = {rmem[pc + 1], rmem[pc]} + x;
                    3'b110:  ea = {rmem[pc + 1], rmem[pc]} + y;
                    default: ea = pc;                    // Immediate
                endcase
                pc = pc + ((op[3:2] == 2'b11 || op[4:2] == 3'b110) ? 16'd2 : 16'd1);
            end
            m   = rmem[ea];
            upd = 1'b1;
            sv  = 8'h00;
            case (op)
                8'hA9, 8'hA5, 8'hAD, 8'hBD, 8'hB9: a = m;
                8'hA2, 8'hA6, 8'hAE: x = m;
                8'hA0, 8'hA4, 8'hAC: y = m;
                8'hE8: x = x + 1'b1;
                8'hC8: y = y + 1'b1;
                8'hCA: x = x - 1'b1;
                8'h88: y = y - 1'b1;
                8'hAA: x = a;
                8'hA8: y = a;
                8'h8A: a = x;
                8'h98: a = y;
                8'h18: c = 1'b0;
                8'h38: c = 1'b1;
                8'h4C: begin
                    t = {rmem[pc + 1], rmem[pc]};
                    done = (t == pc - 1'b1);
                    pc = t;
                end
                default: ;
            endcase
            if (op[1:0] == 2'b01) begin
                case (op[7:5])
                    3'd0: a = a | m;
                    3'd1: a = a & m;
                    3'd2: a = a ^ m;
                    3'd3, 3'd7: begin                    // SBC runs as ADC of ~m
                        if (op[7:5] == 3'd7)
                            m = ~m;
                        s = {1'b0, a} + {1'b0, m} + c;
                        v = (a[7] == m[7]) && (s[7] != a[7]);
                        c = s[8];
                        a = s[7:0];
                    end
                    3'd6: sv = a;
                    default: ;
                endcase
            end
            r = (op inside {8'hE0, 8'hE4, 8'hEC}) ? x :
                (op inside {8'hC0, 8'hC4, 8'hCC}) ? y : sv;
            if (op inside {8'hE0, 8'hE4, 8'hEC, 8'hC0, 8'hC4, 8'hCC} ||
                (op[1:0] == 2'b01 && op[7:5] == 3'd6)) begin  // Compare
                c = (r >= m);
                r = r - m;
            end else if (op inside {8'hA2, 8'hA6, 8'hAE, 8'hE8, 8'hCA, 8'hAA}) begin
                r = x;
            end else if (op inside {8'hA0, 8'hA4, 8'hAC, 8'hC8, 8'h88, 8'hA8}) begin
                r = y;
            end else if (op[1:0] == 2'b01 && op[7:5] != 3'd4) begin
                r = a;
            end else if (op inside {8'h8A, 8'h98}) begin
                r = a;
            end else begin
                upd = 1'b0;
            end
            if (upd) begin
                n = r[7];
                z = (r == 8'h00);
            end
            if ((op[1:0] == 2'b01 && op[7:5] == 3'd4) ||
                op inside {8'h84, 8'h8C, 8'h86, 8'h8E}) begin
                r = (op[1:0] == 2'b01) ? a : op[1] ? x : y;
                rmem[ea] = r;
                exp_addr.push_back(ea);
                exp_data.push_back(r);
            end
            if (op[4:0] == 5'b10000) begin               // Conditional branch
                case (op[7:6])
                    2'b00:   f = n;
                    2'b01:   f = v;
                    2'b10:   f = c;
                    default: f = z;
                endcase
                m  = rmem[pc];
                pc = pc + 1'b1;
                if (f == op[5])
                    pc = pc + {{8{m[7]}}, m};
            end
        end
        return count;
    endfunction

    // ------------------------------------------------------------------
    // Stimulus, reset and reset vector check
    // ------------------------------------------------------------------
    initial begin
        RESET = 1'b1;
        lfsr  = SEED;
        build_program();
        for (int i = 0; i < 65536; i++)
            rmem[i] = mem[i];
        limit = run_reference() * 6 + 50;
        repeat (5) @(posedge CLK);
        #10 RESET = 1'b0;
        repeat (3) @(posedge CLK);                       // RST1, RST2, RST3
        @(negedge CLK);
        check_value("reset vector", {mem[RESET_VECTOR + 1], mem[RESET_VECTOR]}, addr);
    end

    // Compare each DUT write with the reference list
    initial begin
        wr_idx = 0;
        while (exp_addr.size() == 0 || wr_idx < exp_addr.size()) begin
            @(negedge CLK);
            if (!RESET && wreq === 1'b1) begin
                check_value($sformatf("write %0d addr", wr_idx), exp_addr[wr_idx], addr);
                check_value($sformatf("write %0d data", wr_idx), {8'h00, exp_data[wr_idx]},
                            {8'h00, dout});
                wr_idx++;
            end
        end
        $display("test passed");
        $finish;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge CLK);
            cycles++;
            if (limit > 0 && cycles > limit) begin
                $display("The run reached its cycle limit before all writes arrived");
                $display("test failed");
                $fatal(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: cpu/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    output addr_t addr,   // Memory address
    input  byte_t din,    // Read data, same cycle
    output byte_t dout,   // Write data
    output logic  wreq    // Write strobe
);

    byte_t  opcode;
    ustep_e ustep;
    ctrl_t  ctrl;
    logic   branch_taken;
    logic   exec_en;
    byte_t  a_val;
    byte_t  b_val;
    byte_t  x_val;
    byte_t  y_val;
    byte_t  store_data;
    byte_t  result;
    flags_t flags;
    flags_t new_flags;

    cpu_sequencer u_seq (
        .CLK          (CLK),
        .RESET        (RESET),
        .din          (din),
        .ctrl         (ctrl),
        .branch_taken (branch_taken),
        .store_data   (store_data),
        .x_val        (x_val),
        .y_val        (y_val),
        .opcode       (opcode),
        .ustep        (ustep),
        .exec_en      (exec_en),
        .addr         (addr),
        .dout         (dout),
        .wreq         (wreq)
    );

    cpu_decoder u_dec (
        .opcode       (opcode),
        .ustep        (ustep),
        .flags        (flags),
        .ctrl         (ctrl),
        .branch_taken (branch_taken)
    );

    cpu_regfile u_regs (
        .CLK        (CLK),
        .RESET      (RESET),
        .ctrl       (ctrl),
        .exec_en    (exec_en),
        .din        (din),
        .result     (result),
        .new_flags  (new_flags),
        .a_val      (a_val),
        .b_val      (b_val),
        .x_val      (x_val),
        .y_val      (y_val),
        .store_data (store_data),
        .flags      (flags)
    );

    cpu_alu u_alu (
        .op        (ctrl.alu_op),
        .a_val     (a_val),
        .b_val     (b_val),
        .flags_in  (flags),
        .result    (result),
        .flags_out (new_flags)
    );

endmodule

`default_nettype wire

// File: cpu/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer import cpu_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  byte_t  din,
    input  ctrl_t  ctrl,
    input  logic   branch_taken,
    input  byte_t  store_data,
    input  byte_t  x_val,
    input  byte_t  y_val,
    output byte_t  opcode,
    output ustep_e ustep,
    output logic   exec_en,
    output addr_t  addr,
    output byte_t  dout,
    output logic   wreq
);

    addr_t         pc;
    addr_t         ea;          // Effective address
    logic          am;          // Address mode, 1 selects EA
    byte_t         tr;          // Low byte of address under construction
    logic          cout;        // Carry out of indexed low byte
    logic          hop;         // Operand byte consumed in EXEC
    addr_t         pc_inc;
    addr_t         rel_target;
    logic [DATA_W:0] idx_sum;
    byte_t         idx_hi;

    assign pc_inc     = pc + 1'b1;
    assign rel_target = pc_inc + {{(ADDR_W-DATA_W){din[DATA_W-1]}}, din};  // Signed offset
    assign idx_sum    = {1'b0, din} + {1'b0, (ustep == ABX_LO) ? x_val : y_val};
    assign idx_hi     = din + {{(DATA_W-1){1'b0}}, cout};                  // Page carry

    assign addr    = am ? ea : pc;
    assign exec_en = (ustep == EXEC);

    // ------------------------------------------------------------------
    // Microstep sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            ustep <= RST1;
            wreq  <= 1'b0;
            am    <= 1'b0;
        end else begin
            case (ustep)
                FETCH: begin
                    opcode <= din;
                    pc     <= pc_inc;
                    hop    <= 1'b0;
                    casez (din)                                   // Addressing bits
                        8'b???_010_01,
                        8'b101_000_?0,
                        8'b11?_000_00: begin                      // Immediate
                            ustep <= EXEC;
                            hop   <= 1'b1;
                        end
                        8'b???_001_01,
                        8'b1??_001_00,
                        8'b10?_001_10: ustep <= ZP;
                        8'b???_011_01,
                        8'b1??_011_00,
                        8'b10?_011_10,
                        8'h4C:         ustep <= ABS_LO;           // Absolute and JMP
                        8'b???_111_01: ustep <= ABX_LO;
                        8'b???_110_01: ustep <= ABY_LO;
                        8'b???_100_00: ustep <= REL;              // Conditional branch
                        default:       ustep <= EXEC;             // Implied or unknown
                    endcase
                end
                ZP: begin
                    ea    <= {{(ADDR_W-DATA_W){1'b0}}, din};
                    am    <= 1'b1;
                    pc    <= pc_inc;
                    ustep <= EXEC;
                end
                ABS_LO: begin
                    tr    <= din;
                    pc    <= pc_inc;
                    ustep <= ABS_HI;
                end
                ABS_HI: begin
                    if (ctrl.is_jmp) begin
                        pc    <= {din, tr};                       // Jump target
                        ustep <= FETCH;
                    end else begin
                        ea    <= {din, tr};
                        am    <= 1'b1;
                        pc    <= pc_inc;
                        ustep <= EXEC;
                    end
                end
                ABX_LO, ABY_LO: begin
                    {cout, tr} <= idx_sum;
                    pc         <= pc_inc;
                    ustep      <= IDX_HI;
                end
                IDX_HI: begin
                    ea    <= {idx_hi, tr};
                    am    <= 1'b1;
                    pc    <= pc_inc;
                    ustep <= (cout || ctrl.is_store) ? LAT : EXEC;  // Page cross or store
                end
                LAT: ustep <= EXEC;
                EXEC: begin
                    if (hop)
                        pc <= pc_inc;                             // Skip immediate operand
                    if (ctrl.is_store) begin
                        dout  <= store_data;
                        wreq  <= 1'b1;
                        ustep <= STORE;
                    end else begin
                        am    <= 1'b0;
                        ustep <= FETCH;
                    end
                end
                STORE: begin
                    wreq  <= 1'b0;                                // One write cycle
                    am    <= 1'b0;
                    ustep <= FETCH;
                end
                REL: begin
                    if (branch_taken) begin
                        pc    <= rel_target;
                        ustep <= (rel_target[ADDR_W-1:DATA_W] == pc_inc[ADDR_W-1:DATA_W]) ?
                                 REL_DONE : REL_PAGE;
                    end else begin
                        pc    <= pc_inc;
                        ustep <= FETCH;
                    end
                end
                REL_PAGE: ustep <= REL_DONE;                      // Extra cycle for new page
                REL_DONE: ustep <= FETCH;
                RST1: begin
                    pc    <= RESET_VECTOR;
                    ustep <= RST2;
                end
                RST2: begin
                    tr    <= din;                                 // Vector low byte
                    pc    <= pc_inc;
                    ustep <= RST3;
                end
                RST3: begin
                    pc    <= {din, tr};
                    ustep <= FETCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cpu/cpu_decoder.sv
`default_nettype none

module cpu_decoder import cpu_pkg::*; (
    input  byte_t  opcode,
    input  ustep_e ustep,
    input  flags_t flags,
    output ctrl_t  ctrl,
    output logic   branch_taken
);

    logic g1_ok;   // Group one opcode with a supported mode

    assign g1_ok = (opcode[4:2] inside {3'b001, 3'b010, 3'b011, 3'b110, 3'b111}) &&
                   (opcode != 8'h89);

    // Condition flag picked by bits 7..6 and compared to bit 5
    always_comb begin
        case (opcode[7:6])
            2'b00:   branch_taken = (flags.n == opcode[5]);
            2'b01:   branch_taken = (flags.v == opcode[5]);
            2'b10:   branch_taken = (flags.c == opcode[5]);
            default: branch_taken = (flags.z == opcode[5]);
        endcase
    end

    // ------------------------------------------------------------------
    // Opcode to datapath controls
    // ------------------------------------------------------------------
    always_comb begin
        ctrl = '0;                                                // No-op by default
        casez (opcode)
            8'hA0, 8'hA4, 8'hAC,                                  // LDY
            8'hA2, 8'hA6, 8'hAE: begin                            // LDX
                ctrl.alu_op     = ALU_PASS_B;
                ctrl.b_from_mem = 1'b1;
                ctrl.reg_wr     = 1'b1;
                ctrl.dst        = opcode[1] ? REG_X : REG_Y;
                ctrl.flag_wr    = 1'b1;
            end
            8'h84, 8'h8C,                                         // STY
            8'h86, 8'h8E: begin                                   // STX
                ctrl.store_sel = opcode[1] ? REG_X : REG_Y;
                ctrl.is_store  = 1'b1;
            end
            8'hC0, 8'hC4, 8'hCC,                                  // CPY
            8'hE0, 8'hE4, 8'hEC: begin                            // CPX
                ctrl.alu_op     = ALU_CMP;
                ctrl.a_sel      = opcode[5] ? REG_X : REG_Y;
                ctrl.b_from_mem = 1'b1;
                ctrl.flag_wr    = 1'b1;
            end
            8'hE8, 8'hC8, 8'hCA, 8'h88: begin                     // INX INY DEX DEY
                ctrl.alu_op  = (opcode[6] && !opcode[1]) ? ALU_INC : ALU_DEC;
                ctrl.a_sel   = opcode[1] ? REG_X : (opcode == 8'hE8) ? REG_X : REG_Y;
                ctrl.dst     = ctrl.a_sel;
                ctrl.reg_wr  = 1'b1;
                ctrl.flag_wr = 1'b1;
            end
            8'hAA, 8'hA8, 8'h8A, 8'h98: begin                     // Transfers
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.b_sel   = (opcode == 8'h8A) ? REG_X : (opcode == 8'h98) ? REG_Y : REG_A;
                ctrl.dst     = (opcode == 8'hAA) ? REG_X : (opcode == 8'hA8) ? REG_Y : REG_A;
                ctrl.reg_wr  = 1'b1;
                ctrl.flag_wr = 1'b1;
            end
            8'h18, 8'h38: begin                                   // CLC SEC
                ctrl.alu_op  = opcode[5] ? ALU_SET_C : ALU_CLR_C;
                ctrl.flag_wr = 1'b1;
            end
            8'h4C: ctrl.is_jmp = 1'b1;
            8'b???_???_01: begin                                  // ORA .. SBC
                if (g1_ok) begin
                    ctrl.alu_op     = alu_op_e'({1'b0, opcode[7:5]});
                    ctrl.b_from_mem = 1'b1;
                    ctrl.is_store   = (opcode[7:5] == 3'b100);      // STA
                    ctrl.flag_wr    = (opcode[7:5] != 3'b100);
                    ctrl.reg_wr     = (opcode[7:5] != 3'b100) && (opcode[7:5] != 3'b110);
                end
            end
            default: ;
        endcase
        if (ustep != EXEC) begin                                  // Writeback only in EXEC
            ctrl.reg_wr  = 1'b0;
            ctrl.flag_wr = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: cpu/cpu_regfile.sv
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  ctrl_t  ctrl,
    input  logic   exec_en,
    input  byte_t  din,
    input  byte_t  result,
    input  flags_t new_flags,
    output byte_t  a_val,
    output byte_t  b_val,
    output byte_t  x_val,
    output byte_t  y_val,
    output byte_t  store_data,
    output flags_t flags
);

    byte_t  a_reg;
    byte_t  x_reg;
    byte_t  y_reg;
    flags_t p_reg;

    function automatic byte_t pick(reg_sel_e sel, byte_t a, byte_t x, byte_t y);
        case (sel)
            REG_X:   return x;
            REG_Y:   return y;
            default: return a;
        endcase
    endfunction

    assign a_val      = pick(ctrl.a_sel, a_reg, x_reg, y_reg);
    assign b_val      = ctrl.b_from_mem ? din : pick(ctrl.b_sel, a_reg, x_reg, y_reg);
    assign store_data = pick(ctrl.store_sel, a_reg, x_reg, y_reg);  // STA STX STY
    assign x_val      = x_reg;                                      // Index to sequencer
    assign y_val      = y_reg;
    assign flags      = p_reg;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
            p_reg <= '0;
        end else if (exec_en) begin
            if (ctrl.reg_wr) begin
                case (ctrl.dst)
                    REG_X:   x_reg <= result;
                    REG_Y:   y_reg <= result;
                    default: a_reg <= result;
                endcase
            end
            if (ctrl.flag_wr)
                p_reg <= new_flags;
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_alu.sv
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  byte_t   a_val,
    input  byte_t   b_val,
    input  flags_t  flags_in,
    output byte_t   result,
    output flags_t  flags_out
);

    logic            sub;       // Subtract or compare
    byte_t           b_eff;     // Operand B, inverted for subtraction
    logic            carry_in;
    logic [DATA_W:0] sum;
    logic            nz_upd;    // Result sets N and Z

    assign sub      = (op == ALU_SBC) || (op == ALU_CMP);
    assign b_eff    = sub ? ~b_val : b_val;
    assign carry_in = (op == ALU_CMP) ? 1'b1 : flags_in.c;       // CMP ignores C
    assign sum      = {1'b0, a_val} + {1'b0, b_eff} + {{DATA_W{1'b0}}, carry_in};

    always_comb begin
        result    = a_val;
        flags_out = flags_in;
        nz_upd    = 1'b1;
        case (op)
            ALU_OR:  result = a_val | b_val;
            ALU_AND: result = a_val & b_val;
            ALU_EOR: result = a_val ^ b_val;
            ALU_ADC, ALU_SBC: begin
                result      = sum[DATA_W-1:0];
                flags_out.c = sum[DATA_W];
                flags_out.v = (a_val[DATA_W-1] == b_eff[DATA_W-1]) &&
                              (sum[DATA_W-1] != a_val[DATA_W-1]);      // Signed overflow
            end
            ALU_CMP: begin
                result      = sum[DATA_W-1:0];                      // Difference for N and Z
                flags_out.c = sum[DATA_W];                          // No borrow
            end
            ALU_PASS_A: result = a_val;
            ALU_PASS_B: result = b_val;                             // Loads and transfers
            ALU_INC:    result = a_val + 1'b1;
            ALU_DEC:    result = a_val - 1'b1;
            ALU_SET_C: begin
                flags_out.c = 1'b1;
                nz_upd      = 1'b0;
            end
            ALU_CLR_C: begin
                flags_out.c = 1'b0;
                nz_upd      = 1'b0;
            end
            default: nz_upd = 1'b0;
        endcase
        if (nz_upd) begin
            flags_out.n = result[DATA_W-1];
            flags_out.z = (result == '0);
        end
    end

endmodule

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ------------------------------------------------------------------
    // Widths and vectors
    // ------------------------------------------------------------------
    localparam int DATA_W = 8;                              // Data bus
    localparam int ADDR_W = 16;                             // Address bus
    localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC;  // Low byte of start address

    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Status byte in 6502 bit order
    typedef struct packed {
        logic n;    // Negative
        logic v;    // Overflow
        logic one;  // Unused bit
        logic b;    // Break
        logic d;    // Decimal
        logic i;    // Interrupt mask
        logic z;    // Zero
        logic c;    // Carry
    } flags_t;

    // ------------------------------------------------------------------
    // Microsteps
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        FETCH,      // Opcode read
        ZP,         // Zero page address byte
        ABS_LO,     // Absolute low byte
        ABS_HI,     // Absolute high byte
        ABX_LO,     // Low byte plus X
        ABY_LO,     // Low byte plus Y
        IDX_HI,     // High byte plus carry
        LAT,        // Extra address cycle
        EXEC,       // Execute and writeback
        STORE,      // Memory write
        REL,        // Branch offset
        REL_PAGE,   // Page crossed
        REL_DONE,   // Branch taken
        RST1,
        RST2,
        RST3
    } ustep_e;

    // ALU operations, group one ones follow opcode bits 7..5
    typedef enum logic [3:0] {
        ALU_OR,
        ALU_AND,
        ALU_EOR,
        ALU_ADC,
        ALU_PASS_A,
        ALU_PASS_B,
        ALU_CMP,
        ALU_SBC,
        ALU_INC,
        ALU_DEC,
        ALU_SET_C,
        ALU_CLR_C
    } alu_op_e;

    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_e;

    // Decoder output
    typedef struct packed {
        alu_op_e  alu_op;
        reg_sel_e a_sel;       // ALU operand A
        reg_sel_e b_sel;       // ALU operand B when not memory
        logic     b_from_mem;  // Operand B is din
        logic     reg_wr;      // Write result to dst
        reg_sel_e dst;
        logic     flag_wr;     // Write new flags to P
        reg_sel_e store_sel;   // Register driven to memory
        logic     is_store;
        logic     is_jmp;
    } ctrl_t;

endpackage

`default_nettype wire
